//--- verilog.f
src/ahbl_pkg.sv
src/ahbl_addr_decoder.sv
src/ahbl_mem_slave.sv
src/ahbl_resp_mux.sv
src/ahbl_slave_monitor.sv
src/ahbl_mem_subsys.sv
test/tb_ahbl_mem_subsys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compiles the testbench with Verilator, runs it and checks the log
set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=tb_ahbl_mem_subsys
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -f verilog.f

./obj_dir/V"$TOP" 2>&1 | tee "$LOG"

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
	echo "Simulation reported failure, see $LOG"
	exit 1
fi

echo "Simulation finished without failure"

//--- test/tb_ahbl_mem_subsys.sv
// Runs the DUT with default parameters only; the fill pass must come first so every shadow byte is known
`timescale 1ns/10ps

module tb_ahbl_mem_subsys;

	localparam int N_SLAVES    = 4;
	localparam int MEM_WORDS   = 64;
	localparam int WAIT_STATES = 1;
	localparam int N_BYTES     = N_SLAVES * MEM_WORDS * 4;   // Mapped range
	localparam int N_RAND      = 800;
	localparam int N_PLANNED   = 2 * N_BYTES / 4 + 24 * N_SLAVES + 8 + N_RAND;
	localparam int MAX_CYCLES  = 4 * N_PLANNED * (WAIT_STATES + 2) + 200;

	logic        clk = 1'b0;
	logic        rst_n;
	logic [31:0] haddr;
	logic        hwrite;
	logic [1:0]  htrans;
	logic [2:0]  hsize;
	logic [31:0] hwdata;
	logic [31:0] hrdata;
	logic        hready;
	logic        hresp;

	logic [7:0]  shadow [N_BYTES];  // Byte image of all slaves
	logic [31:0] lfsr = 32'd68617;
	logic [31:0] wdata_next = '0;   // Write data of the address phase now on the bus
	logic [65:0] exp_q [$];         // {err, chk, rdata, mask} per active transfer
	logic [65:0] exp_entry;
	int          value_errs = 0;
	int          proto_errs = 0;
	int          n_issued = 0;
	int          n_done = 0;
	int          cycles = 0;

	// Expectation of the data phase in flight
	logic        exp_valid;
	logic        exp_err;
	logic        exp_chk;           // Read data is compared
	logic [31:0] exp_rdata;
	logic [31:0] exp_mask;          // Byte lanes that carry read data
	int          exp_len;           // Cycles with hready low
	int          stall;

	ahbl_mem_subsys i_ahbl_mem_subsys (
		.clk    (clk),
		.rst_n  (rst_n),
		.haddr  (haddr),
		.hwrite (hwrite),
		.htrans (htrans),
		.hsize  (hsize),
		.hwdata (hwdata),
		.hrdata (hrdata),
		.hready (hready),
		.hresp  (hresp)
	);

	always #20 clk = ~clk;  // 40 ns period

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]}; // One step per bit
		end
	endtask

	function automatic logic [31:0] fill_word(input logic [31:0] a);
		return {a[15:0] ^ a[31:16] ^ 16'hc35a, ~a[15:0]};
	endfunction

	// Predicts the response, then puts the address phase on the bus at the next accepting edge
	task automatic drive_transfer(input logic [1:0] t, input logic [31:0] a, input logic w,
			input logic [2:0] s, input logic [31:0] d);
		logic        act;
		logic        ok_align;
		logic        err;
		logic [3:0]  lanes;
		logic [31:0] rd;
		logic [31:0] mask;
		int          base;
		act = t[1];
		case (s)
			ahbl_pkg::hsize_byte: ok_align = 1'b1;
			ahbl_pkg::hsize_half: ok_align = (a[0] == 1'b0);
			ahbl_pkg::hsize_word: ok_align = (a[1:0] == 2'b00);
			default:              ok_align = 1'b0;
		endcase
		lanes = (s == ahbl_pkg::hsize_byte) ? 4'b0001 << a[1:0] :
			(s == ahbl_pkg::hsize_half) ? 4'b0011 << {a[1], 1'b0} : 4'b1111;
		err  = act && (a >= N_BYTES || !ok_align);
		base = int'(a) & ~3;                  // Only used for mapped addresses
		rd   = '0;
		mask = (a >= N_BYTES) ? '1 : '0;      // Unmapped reads return all zero
		for (int b = 0; b < 4; b++) begin
			if (act && !err && lanes[b]) begin
				mask[8*b +: 8] = 8'hff;
				if (w)
					shadow[base + b] = d[8*b +: 8];
				else
					rd[8*b +: 8] = shadow[base + b];
			end
		end
		if (act) begin
			exp_q.push_back({err, !w && (!err || a >= N_BYTES), rd, mask});
			n_issued++;
		end
		@(posedge clk);
		while (!hready)
			@(posedge clk);                    // Address held during wait states
		hwdata <= wdata_next;                 // Data of the transfer taken on this edge
		haddr  <= a;
		htrans <= t;
		hwrite <= w;
		hsize  <= s;
		wdata_next = d;
	endtask

	// Follows the data phase on the bus
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exp_valid <= 1'b0;
			exp_err   <= 1'b0;
			exp_chk   <= 1'b0;
			exp_len   <= 0;
			stall     <= 0;
		end else if (hready) begin
			exp_valid <= htrans[1];            // Address phase accepted now
			stall     <= 0;
			if (htrans[1]) begin
				exp_entry = exp_q.pop_front();
				{exp_err, exp_chk, exp_rdata, exp_mask} <= exp_entry;
				exp_len <= exp_entry[65] ? 1 : WAIT_STATES;
			end
			if (exp_valid)
				n_done <= n_done + 1;
		end else begin
			stall <= stall + 1;
		end
	end

	a_resp_value: assert property (@(posedge clk) disable iff (!rst_n)
		exp_valid |-> hresp == exp_err)
		else begin
			value_errs++;
			$display("[ERROR] hresp: got %h, expected %h", $sampled(hresp), $sampled(exp_err));
		end

	a_rdata_value: assert property (@(posedge clk) disable iff (!rst_n)
		exp_valid && hready && exp_chk |-> (hrdata & exp_mask) == exp_rdata)
		else begin
			value_errs++;
			$display("[ERROR] hrdata: got %h, expected %h under mask %h",
				$sampled(hrdata) & $sampled(exp_mask), $sampled(exp_rdata), $sampled(exp_mask));
		end

	a_phase_len: assert property (@(posedge clk) disable iff (!rst_n)
		exp_valid && hready |-> stall == exp_len)
		else begin
			value_errs++;
			$display("[ERROR] hready low cycles: got %h, expected %h", $sampled(stall),
				$sampled(exp_len));
		end

	a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
		exp_valid && !hready |-> stall < exp_len)
		else begin
			proto_errs++;
			$display("Data phase held hready low longer than expected");
		end

	a_idle_phase: assert property (@(posedge clk) disable iff (!rst_n)
		!exp_valid |-> hready && hresp == ahbl_pkg::hresp_okay)
		else begin
			proto_errs++;
			$display("Bus not ready with OKAY while no transfer is in its data phase");
		end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles: %0d value errors, %0d protocol errors",
				cycles, value_errs, proto_errs);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial begin
		logic [31:0] a;
		logic [31:0] r;
		logic [31:0] d;
		logic [31:0] base;
		logic [2:0]  s;
		logic [1:0]  t;
		rst_n  <= 1'b0;
		haddr  <= '0;
		hwrite <= 1'b0;
		htrans <= ahbl_pkg::htrans_idle;
		hsize  <= ahbl_pkg::hsize_word;
		hwdata <= '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		// Word fill of every slave, then full read-back
		for (int i = 0; i < N_BYTES; i += 4)
			drive_transfer(ahbl_pkg::htrans_nonseq, i, 1'b1, ahbl_pkg::hsize_word, fill_word(i));
		for (int i = 0; i < N_BYTES; i += 4)
			drive_transfer(ahbl_pkg::htrans_seq, i, 1'b0, ahbl_pkg::hsize_word, '0);

		for (int k = 0; k < N_SLAVES; k++) begin
			base = k * MEM_WORDS * 4 + 4 * (k + 5);
			for (int b = 0; b < 4; b++) begin   // Bytes into every lane
				rand_bits(32, r);
				drive_transfer(ahbl_pkg::htrans_nonseq, base + b, 1'b1, ahbl_pkg::hsize_byte, r);
			end
			drive_transfer(ahbl_pkg::htrans_nonseq, base, 1'b0, ahbl_pkg::hsize_word, '0);
			for (int h = 0; h < 4; h += 2) begin
				rand_bits(32, r);
				drive_transfer(ahbl_pkg::htrans_seq, base + h, 1'b1, ahbl_pkg::hsize_half, r);
				drive_transfer(ahbl_pkg::htrans_seq, base, 1'b0, ahbl_pkg::hsize_word, '0);
			end
			rand_bits(32, r);
			drive_transfer(ahbl_pkg::htrans_nonseq, base + 1, 1'b1, ahbl_pkg::hsize_byte, r);
			for (int b = 0; b < 4; b++)
				drive_transfer(ahbl_pkg::htrans_nonseq, base + b, 1'b0, ahbl_pkg::hsize_byte, '0);
			drive_transfer(ahbl_pkg::htrans_nonseq, base + 2, 1'b0, ahbl_pkg::hsize_half, '0);

			// Misaligned accesses leave the word alone
			base = base + 16;
			rand_bits(32, r);
			drive_transfer(ahbl_pkg::htrans_nonseq, base + 1, 1'b1, ahbl_pkg::hsize_half, r);
			drive_transfer(ahbl_pkg::htrans_nonseq, base + 3, 1'b0, ahbl_pkg::hsize_half, '0);
			for (int o = 1; o < 4; o++) begin
				drive_transfer(ahbl_pkg::htrans_nonseq, base + o, 1'b1, ahbl_pkg::hsize_word, ~r);
				drive_transfer(ahbl_pkg::htrans_nonseq, base + o, 1'b0, ahbl_pkg::hsize_word, '0);
			end
			drive_transfer(ahbl_pkg::htrans_nonseq, base, 1'b0, ahbl_pkg::hsize_word, '0);
		end

		for (int k = 0; k < 4; k++) begin      // Above the mapped range
			a = N_BYTES + k * 32'h3fff_fffc;
			drive_transfer(ahbl_pkg::htrans_nonseq, a, 1'b1, ahbl_pkg::hsize_word, 32'hdead_beef);
			drive_transfer(ahbl_pkg::htrans_nonseq, a, 1'b0, ahbl_pkg::hsize_word, '0);
		end

		// Back-to-back random traffic, some idle, BUSY and unmapped
		for (int n = 0; n < N_RAND; n++) begin
			rand_bits(3, r);
			t = (r == 0) ? ahbl_pkg::htrans_idle : (r == 1) ? ahbl_pkg::htrans_busy :
				r[0] ? ahbl_pkg::htrans_seq : ahbl_pkg::htrans_nonseq;
			rand_bits(2, r);
			s = (r[1:0] == 2'b11) ? ahbl_pkg::hsize_word : {1'b0, r[1:0]};
			rand_bits(10, a);
			rand_bits(2, r);
			if (r != 0)
				a = a & ~((32'd1 << s) - 32'd1); // Mostly aligned
			rand_bits(3, r);
			if (r == 0)
				a = a + N_BYTES;
			rand_bits(32, d);
			rand_bits(1, r);
			drive_transfer(t, a, r[0], s, d);
		end

		drive_transfer(ahbl_pkg::htrans_idle, '0, 1'b0, ahbl_pkg::hsize_word, '0);
		drive_transfer(ahbl_pkg::htrans_idle, '0, 1'b0, ahbl_pkg::hsize_word, '0);
		repeat (2) @(posedge clk);
		if (n_done != n_issued) begin
			proto_errs++;
			$display("Only %0d of %0d transfers completed", n_done, n_issued);
		end
		$display("Transfers %0d, value errors %0d, protocol errors %0d",
			n_done, value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- src/ahbl_mem_subsys.sv
// Single AHB-Lite master port; HBURST, HPROT and HMASTLOCK are not taken, BUSY acts as IDLE
`timescale 1ns/10ps

module ahbl_mem_subsys #(
	parameter int W_ADDR        = 32,
	parameter int W_DATA        = 32,
	parameter int N_SLAVES      = 4,
	parameter int MEM_WORDS     = 64,
	parameter int WAIT_STATES   = 1,
	parameter int MAX_BUS_STALL = 4
) (
	input  logic              clk,
	input  logic              rst_n,

	input  logic [W_ADDR-1:0] haddr,
	input  logic              hwrite,
	input  logic [1:0]        htrans,
	input  logic [2:0]        hsize,
	input  logic [W_DATA-1:0] hwdata,

	output logic [W_DATA-1:0] hrdata,
	output logic              hready,
	output logic              hresp
);

	localparam int W_SEL = $clog2(N_SLAVES + 1);

	logic [N_SLAVES-1:0]        hsel;
	logic [W_SEL-1:0]           dph_sel;
	logic                       dflt_hready;
	logic                       dflt_hresp;
	logic [N_SLAVES-1:0]        slv_hready_resp;
	logic [N_SLAVES-1:0]        slv_hresp;
	logic [N_SLAVES*W_DATA-1:0] slv_hrdata;

	ahbl_addr_decoder #(
		.W_ADDR    (W_ADDR),
		.N_SLAVES  (N_SLAVES),
		.MEM_WORDS (MEM_WORDS)
	) i_ahbl_addr_decoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.haddr       (haddr),
		.htrans      (htrans),
		.hready      (hready),
		.hsel        (hsel),
		.dph_sel     (dph_sel),
		.dflt_hready (dflt_hready),
		.dflt_hresp  (dflt_hresp)
	);

	// One memory and one watcher per region
	for (genvar i = 0; i < N_SLAVES; i++) begin : g_slave
		ahbl_mem_slave #(
			.W_ADDR      (W_ADDR),
			.W_DATA      (W_DATA),
			.MEM_WORDS   (MEM_WORDS),
			.WAIT_STATES (WAIT_STATES)
		) i_ahbl_mem_slave (
			.clk         (clk),
			.rst_n       (rst_n),
			.hsel        (hsel[i]),
			.hready_in   (hready),
			.haddr       (haddr),
			.hwrite      (hwrite),
			.htrans      (htrans),
			.hsize       (hsize),
			.hwdata      (hwdata),
			.hready_resp (slv_hready_resp[i]),
			.hresp       (slv_hresp[i]),
			.hrdata      (slv_hrdata[i*W_DATA +: W_DATA])
		);

		ahbl_slave_monitor #(
			.W_ADDR        (W_ADDR),
			.MAX_BUS_STALL (MAX_BUS_STALL)
		) i_ahbl_slave_monitor (
			.clk         (clk),
			.rst_n       (rst_n),
			.hsel        (hsel[i]),
			.hready      (hready),
			.htrans      (htrans),
			.hready_resp (slv_hready_resp[i]),
			.hresp       (slv_hresp[i])
		);
	end

	ahbl_resp_mux #(
		.W_DATA   (W_DATA),
		.N_SLAVES (N_SLAVES)
	) i_ahbl_resp_mux (
		.dph_sel         (dph_sel),
		.slv_hready_resp (slv_hready_resp),
		.slv_hresp       (slv_hresp),
		.slv_hrdata      (slv_hrdata),
		.dflt_hready     (dflt_hready),
		.dflt_hresp      (dflt_hresp),
		.hready          (hready),
		.hresp           (hresp),
		.hrdata          (hrdata)
	);

endmodule

//--- src/ahbl_slave_monitor.sv
// Checks one slave's own response signals only; MAX_BUS_STALL below zero disables the stall check
`timescale 1ns/10ps

module ahbl_slave_monitor #(
	parameter int W_ADDR        = 32,
	parameter int MAX_BUS_STALL = -1
) (
	input logic       clk,
	input logic       rst_n,

	input logic       hsel,
	input logic       hready,        // Combined bus hready
	input logic [1:0] htrans,
	input logic       hready_resp,   // This slave's own outputs
	input logic       hresp
);

	logic active_dph;  // This slave owns an active data phase
	logic err_first;

	// Address bits below the word lane are needed by every slave decode
	if (W_ADDR < 3) begin : g_addr_check
		$error("W_ADDR too small for byte lanes: %0d", W_ADDR);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			active_dph <= 1'b0;
		else if (hready)
			active_dph <= hsel &&
				(htrans == ahbl_pkg::htrans_nonseq || htrans == ahbl_pkg::htrans_seq);
	end

	assign err_first = (hresp == ahbl_pkg::hresp_error) && !hready_resp;

	// IDLE, BUSY or unselected phase completes at once with OKAY
	a_idle_okay: assert property (@(posedge clk) disable iff (!rst_n)
		!active_dph |-> hready_resp && (hresp == ahbl_pkg::hresp_okay))
		else $error("slave answered an inactive data phase");

	// First error cycle is always followed by the releasing one
	a_err_second: assert property (@(posedge clk) disable iff (!rst_n)
		err_first |=> (hresp == ahbl_pkg::hresp_error) && hready_resp)
		else $error("error response not completed in two cycles");

	// ERROR with ready only right after the first error cycle
	a_err_order: assert property (@(posedge clk) disable iff (!rst_n)
		(hresp == ahbl_pkg::hresp_error) && hready_resp |-> $past(err_first))
		else $error("error response without its first cycle");

	if (MAX_BUS_STALL >= 0) begin : g_stall_check
		logic [7:0] stall_ctr;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n)
				stall_ctr <= 8'h0;
			else if (hready_resp)
				stall_ctr <= 8'h0;
			else
				stall_ctr <= stall_ctr + {7'h0, ~&stall_ctr}; // Saturates at 255
		end

		a_stall_limit: assert property (@(posedge clk) disable iff (!rst_n)
			stall_ctr <= MAX_BUS_STALL)
			else $error("slave stalled %0d cycles, limit %0d", stall_ctr, MAX_BUS_STALL);
	end

endmodule

//--- src/ahbl_resp_mux.sv
// Purely combinational; a dph_sel value of N_SLAVES selects the default responder with zero read data
`timescale 1ns/10ps

module ahbl_resp_mux #(
	parameter int W_DATA   = 32,
	parameter int N_SLAVES = 4,
	localparam int W_SEL   = $clog2(N_SLAVES + 1)
) (
	input  logic [W_SEL-1:0]           dph_sel,

	input  logic [N_SLAVES-1:0]        slv_hready_resp,
	input  logic [N_SLAVES-1:0]        slv_hresp,
	input  logic [N_SLAVES*W_DATA-1:0] slv_hrdata,   // Slave i in bits i*W_DATA upwards

	input  logic                       dflt_hready,
	input  logic                       dflt_hresp,

	output logic                       hready,
	output logic                       hresp,
	output logic [W_DATA-1:0]          hrdata
);

	// Default responder unless a slave index matches
	always_comb begin
		hready = dflt_hready;
		hresp  = dflt_hresp;
		hrdata = '0;
		for (int i = 0; i < N_SLAVES; i++) begin
			if (dph_sel == W_SEL'(i)) begin
				hready = slv_hready_resp[i];
				hresp  = slv_hresp[i];
				hrdata = slv_hrdata[i*W_DATA +: W_DATA];
			end
		end
	end

endmodule

//--- src/ahbl_mem_slave.sv
// Plain word memory without reset contents; byte lanes assume W_DATA is 32, sizes above word get ERROR
`timescale 1ns/10ps

module ahbl_mem_slave #(
	parameter int W_ADDR      = 32,
	parameter int W_DATA      = 32,
	parameter int MEM_WORDS   = 64,
	parameter int WAIT_STATES = 1
) (
	input  logic              clk,
	input  logic              rst_n,

	input  logic              hsel,
	input  logic              hready_in,   // Combined hready, high ends the data phase
	input  logic [W_ADDR-1:0] haddr,
	input  logic              hwrite,
	input  logic [1:0]        htrans,
	input  logic [2:0]        hsize,
	input  logic [W_DATA-1:0] hwdata,

	output logic              hready_resp,
	output logic              hresp,
	output logic [W_DATA-1:0] hrdata
);

	localparam int N_LANES = W_DATA / 8;
	localparam int W_WORD  = $clog2(MEM_WORDS);
	localparam int W_WAIT  = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

	logic [W_DATA-1:0] mem [MEM_WORDS];

	// Data phase state
	logic              dph_active;
	logic              dph_err;     // Misaligned, answered with ERROR
	logic              err_done;    // First error cycle has passed
	logic [W_WAIT-1:0] wait_cnt;
	logic              dph_write;
	logic [W_WORD+1:0] dph_addr;    // Byte address inside this slave
	logic [2:0]        dph_size;

	logic              take;
	logic [W_WORD-1:0] dph_word;
	logic [N_LANES-1:0] lane_mask;
	logic              wr_en;

	// Selected and active while the bus accepts a new address phase
	assign take = hsel && hready_in &&
		(htrans == ahbl_pkg::htrans_nonseq || htrans == ahbl_pkg::htrans_seq);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_active <= 1'b0;
			dph_err    <= 1'b0;
			err_done   <= 1'b0;
			wait_cnt   <= '0;
		end else if (hready_in) begin
			dph_active <= take;
			dph_err    <= take && !ahbl_pkg::size_aligned(haddr[1:0], hsize);
			err_done   <= 1'b0;
			wait_cnt   <= '0;
		end else if (dph_active) begin
			if (dph_err)
				err_done <= 1'b1;
			else
				wait_cnt <= wait_cnt + 1'b1; // Stops at WAIT_STATES since we release hready there
		end
	end

	// Payload of the data phase, meaningful only with dph_active
	always_ff @(posedge clk) begin
		if (take) begin
			dph_write <= hwrite;
			dph_addr  <= haddr[W_WORD+1:0];
			dph_size  <= hsize;
		end
	end

	assign dph_word = dph_addr[W_WORD+1:2];

	// Response, idle phases answer ready and OKAY
	always_comb begin
		if (!dph_active)
			hready_resp = 1'b1;
		else if (dph_err)
			hready_resp = err_done; // Low then high, ERROR held for both cycles
		else
			hready_resp = (wait_cnt == W_WAIT'(WAIT_STATES));
	end

	assign hresp = (dph_active && dph_err) ? ahbl_pkg::hresp_error : ahbl_pkg::hresp_okay;

	// Byte lanes touched by the transfer
	always_comb begin
		case (dph_size)
			ahbl_pkg::hsize_byte: lane_mask = N_LANES'(1) << dph_addr[1:0];
			ahbl_pkg::hsize_half: lane_mask = N_LANES'(3) << {dph_addr[1], 1'b0};
			default:              lane_mask = '1; // Word, errors never reach the write port
		endcase
	end

	// Write lands on the edge that closes the data phase, hwdata is valid then
	assign wr_en = dph_active && !dph_err && dph_write && hready_in;

	always_ff @(posedge clk) begin
		if (wr_en) begin
			for (int b = 0; b < N_LANES; b++) begin
				if (lane_mask[b])
					mem[dph_word][8*b +: 8] <= hwdata[8*b +: 8];
			end
		end
	end

	assign hrdata = mem[dph_word]; // Sampled by the master only when hready_resp is high

	a_wait_bound: assert property (@(posedge clk) disable iff (!rst_n)
		wait_cnt <= W_WAIT'(WAIT_STATES))
		else $error("wait counter passed WAIT_STATES: %0d", wait_cnt);

endmodule

//--- src/ahbl_addr_decoder.sv
// Maps N_SLAVES regions of MEM_WORDS*4 bytes from address zero; MEM_WORDS must be a power of two
`timescale 1ns/10ps

module ahbl_addr_decoder #(
	parameter int W_ADDR    = 32,
	parameter int N_SLAVES  = 4,
	parameter int MEM_WORDS = 64,
	localparam int W_SEL    = $clog2(N_SLAVES + 1)
) (
	input  logic                clk,
	input  logic                rst_n,

	input  logic [W_ADDR-1:0]   haddr,
	input  logic [1:0]          htrans,
	input  logic                hready,   // Combined hready from the response mux

	output logic [N_SLAVES-1:0] hsel,
	output logic [W_SEL-1:0]    dph_sel,  // Value N_SLAVES means default responder
	output logic                dflt_hready,
	output logic                dflt_hresp
);

	localparam int OFS_BITS = $clog2(MEM_WORDS * 4); // Byte offset bits inside a region
	localparam int W_REGION = W_ADDR - OFS_BITS;

	logic [W_REGION-1:0] region;
	logic                active;
	logic                mapped;
	logic                dflt_err;  // Data phase belongs to an unmapped active transfer
	logic                dflt_rdy;

	assign region = haddr[W_ADDR-1:OFS_BITS];
	assign mapped = (region < W_REGION'(N_SLAVES));

	// BUSY falls through as inactive
	assign active = (htrans == ahbl_pkg::htrans_nonseq) || (htrans == ahbl_pkg::htrans_seq);

	// Address phase selects, purely combinational
	always_comb begin
		for (int i = 0; i < N_SLAVES; i++) begin
			hsel[i] = active && (region == W_REGION'(i));
		end
	end

	// Owner of the data phase, moves only when an address phase is accepted
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_sel <= W_SEL'(N_SLAVES);
		end else if (hready) begin
			if (active && mapped)
				dph_sel <= W_SEL'(region);
			else
				dph_sel <= W_SEL'(N_SLAVES); // Idle and unmapped both go to the default responder
		end
	end

	// Default responder
	// An unmapped active transfer pulls hready low for one cycle with ERROR,
	// then releases it with ERROR still up
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dflt_err <= 1'b0;
			dflt_rdy <= 1'b1;
		end else if (hready) begin
			dflt_err <= active && !mapped;
			dflt_rdy <= !(active && !mapped);
		end else begin
			dflt_rdy <= 1'b1; // Second error cycle, or some slave is stalling
		end
	end

	assign dflt_hready = dflt_rdy;
	assign dflt_hresp  = dflt_err ? ahbl_pkg::hresp_error : ahbl_pkg::hresp_okay;

	// At most one slave sees an address phase
	a_hsel_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(hsel))
		else $error("decoder drove more than one hsel: %b", hsel);

	// Owner index never points past the default responder
	a_dph_sel_range: assert property (@(posedge clk) disable iff (!rst_n)
		dph_sel <= W_SEL'(N_SLAVES))
		else $error("dph_sel out of range: %0d", dph_sel);

endmodule

//--- src/ahbl_pkg.sv
// AHB-Lite codes shared by all blocks; only byte, halfword and word sizes are supported
package ahbl_pkg;

	// HTRANS codes, bit 1 set marks an active transfer
	localparam logic [1:0] htrans_idle   = 2'b00;
	localparam logic [1:0] htrans_busy   = 2'b01; // Treated like IDLE everywhere
	localparam logic [1:0] htrans_nonseq = 2'b10;
	localparam logic [1:0] htrans_seq    = 2'b11;

	// HSIZE codes
	localparam logic [2:0] hsize_byte = 3'b000;
	localparam logic [2:0] hsize_half = 3'b001;
	localparam logic [2:0] hsize_word = 3'b010;

	// HRESP, AHB-Lite only has the low bit
	localparam logic hresp_okay  = 1'b0;
	localparam logic hresp_error = 1'b1;

	// True when the byte address suits the transfer size
	function automatic logic size_aligned(
		input logic [1:0] addr_lsb,
		input logic [2:0] size
	);
		logic ok;
		case (size)
			hsize_byte: ok = 1'b1;
			hsize_half: ok = ~addr_lsb[0];
			hsize_word: ok = (addr_lsb == 2'b00);
			default:    ok = 1'b0; // Wider than the bus, never legal here
		endcase
		return ok;
	endfunction

endpackage
